// File: rtl/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Register, ALU and memory word width
`define DATA_BITS 32

// Memory depths in words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// Byte address of the first fetch after reset
`define RESET_PC 0

`endif

// File: rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0]
	{
		RTYPE = 6'b000000,
		J     = 6'b000010,
		BEQ   = 6'b000100,
		ADDI  = 6'b001000,
		LW    = 6'b100011,
		SW    = 6'b101011
	} opcodeE;

	// Function field for R-type arithmetic
	typedef enum logic [5:0]
	{
		ADD = 6'b100000,
		SUB = 6'b100010,
		AND = 6'b100100,
		OR  = 6'b100101,
		SLT = 6'b101010
	} functE;

	// ALU operation as carried down the pipe
	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOpE;

	// Execute-stage operand source
	typedef enum logic [1:0]
	{
		NONE   = 2'b00,
		FROM_W = 2'b01,
		FROM_M = 2'b10
	} fwdSelE;

	typedef struct packed
	{
		opcodeE     opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functE      funct;
	} rTypeS;

	typedef struct packed
	{
		opcodeE      opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeS;

	// Same 32 bits, register view or immediate view
	typedef union packed
	{
		rTypeS rType;
		iTypeS iType;
	} instrWord;

endpackage

`default_nettype wire

// File: rtl/controlUnit.sv
`default_nettype none
`timescale 1ns/1ps

module controlUnit (
	input  mipsPkg::instrWord instr,
	output logic              regWrite,
	output logic              memToReg,
	output logic              memWrite,
	output logic              branch,
	output logic              jump,
	output logic              aluSrcImm,
	output logic              regDstRd,
	output mipsPkg::aluOpE    aluOp
);

	import mipsPkg::*;

	always_comb
	begin
		logic knownOp;

		// Bubble unless the opcode says otherwise
		knownOp   = 1'b1;
		regWrite  = 1'b0;
		memToReg  = 1'b0;
		memWrite  = 1'b0;
		branch    = 1'b0;
		jump      = 1'b0;
		aluSrcImm = 1'b0;
		regDstRd  = 1'b0;
		aluOp     = ALU_ADD;

		case (instr.rType.opcode)
			RTYPE:
			begin
				regDstRd = 1'b1;
				// All-zero word lands here as a nop with no write
				case (instr.rType.funct)
					ADD:
					begin
						regWrite = 1'b1;
						aluOp    = ALU_ADD;
					end
					SUB:
					begin
						regWrite = 1'b1;
						aluOp    = ALU_SUB;
					end
					AND:
					begin
						regWrite = 1'b1;
						aluOp    = ALU_AND;
					end
					OR:
					begin
						regWrite = 1'b1;
						aluOp    = ALU_OR;
					end
					SLT:
					begin
						regWrite = 1'b1;
						aluOp    = ALU_SLT;
					end
					default: regWrite = 1'b0;
				endcase
			end
			ADDI:
			begin
				regWrite  = 1'b1;
				aluSrcImm = 1'b1;
			end
			LW:
			begin
				regWrite  = 1'b1;
				memToReg  = 1'b1;
				aluSrcImm = 1'b1;
			end
			// Address only, rt goes out as store data
			SW:
			begin
				memWrite  = 1'b1;
				aluSrcImm = 1'b1;
			end
			BEQ: branch = 1'b1;
			J: jump = 1'b1;
			default: knownOp = 1'b0;
		endcase

		assert (knownOp)
			else $error("controlUnit: undefined opcode %b", instr.rType.opcode);
	end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module regFile (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  writeEn,
	input  logic [4:0]            readAddrA,
	input  logic [4:0]            readAddrB,
	input  logic [4:0]            writeAddr,
	input  logic [`DATA_BITS-1:0] writeData,
	output logic [`DATA_BITS-1:0] readDataA,
	output logic [`DATA_BITS-1:0] readDataB
);

	// r1..r31, r0 is wired to zero below
	logic [`DATA_BITS-1:0] regs [1:31];

	// Falling edge, so a writeback lands before decode samples
	always_ff @(negedge clk)
	begin
		if (rst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEn && (writeAddr != 5'd0))
			regs[writeAddr] <= writeData;
	end

	assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// File: rtl/hazardUnit.sv
`default_nettype none
`timescale 1ns/1ps

module hazardUnit (
	input  logic             clk,
	input  logic             rst,
	input  logic [4:0]       rsD,
	input  logic [4:0]       rtD,
	input  logic [4:0]       rsE,
	input  logic [4:0]       rtE,
	input  logic [4:0]       writeRegE,
	input  logic [4:0]       writeRegM,
	input  logic [4:0]       writeRegW,
	input  logic             regWriteE,
	input  logic             regWriteM,
	input  logic             regWriteW,
	input  logic             memToRegE,
	input  logic             memToRegM,
	input  logic             branchD,
	output logic             stallF,
	output logic             stallD,
	output logic             flushE,
	output logic             forwardAD,
	output logic             forwardBD,
	output mipsPkg::fwdSelE  forwardAE,
	output mipsPkg::fwdSelE  forwardBE
);

	import mipsPkg::*;

	logic lwStall;
	logic branchStall;

	always_comb
	begin
		// Execute operands, M is newer than W so it wins
		if ((rsE != 5'd0) && (rsE == writeRegM) && regWriteM)
			forwardAE = FROM_M;
		else if ((rsE != 5'd0) && (rsE == writeRegW) && regWriteW)
			forwardAE = FROM_W;
		else
			forwardAE = NONE;

		if ((rtE != 5'd0) && (rtE == writeRegM) && regWriteM)
			forwardBE = FROM_M;
		else if ((rtE != 5'd0) && (rtE == writeRegW) && regWriteW)
			forwardBE = FROM_W;
		else
			forwardBE = NONE;

		// Branch comparator, M only
		forwardAD = (rsD != 5'd0) && (rsD == writeRegM) && regWriteM;
		forwardBD = (rtD != 5'd0) && (rtD == writeRegM) && regWriteM;

		// Load in E whose target is read in D
		lwStall = ((rsD == rtE) || (rtD == rtE)) && memToRegE;

		// Branch operand still being computed in E or loaded in M
		branchStall = (branchD && regWriteE && ((writeRegE == rsD) || (writeRegE == rtD)))
			|| (branchD && memToRegM && ((writeRegM == rsD) || (writeRegM == rtD)));

		stallF = lwStall || branchStall;
		stallD = lwStall || branchStall;
		flushE = lwStall || branchStall;
	end

	// Two bubbles drain any load or branch hazard
	stallBounded: assert property (@(posedge clk) disable iff (rst)
		($past(stallF) && $past(stallF, 2)) |-> !stallF)
		else $error("hazardUnit: stall held for more than two cycles");

	// Flushed slot reaches E as a bubble
	flushGivesBubble: assert property (@(posedge clk) disable iff (rst)
		flushE |=> !(regWriteE || memToRegE))
		else $error("hazardUnit: flushed E stage still writes");

endmodule

`default_nettype wire

// File: rtl/mipsCore.sv
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module mipsCore (
	input  logic                  clk,
	input  logic                  rst,
	output logic [`DATA_BITS-1:0] imemAddr,
	input  logic [`DATA_BITS-1:0] imemData,
	output logic [`DATA_BITS-1:0] dmemAddr,
	output logic [`DATA_BITS-1:0] dmemWriteData,
	output logic                  dmemWriteEn,
	input  logic [`DATA_BITS-1:0] dmemReadData
);

	import mipsPkg::*;

	localparam logic [`DATA_BITS-1:0] PC_STEP = 4;

	// Fetch
	logic [`DATA_BITS-1:0] pcF, pcNextF, pcPlus4F;
	// Decode
	instrWord              instrD;
	logic [`DATA_BITS-1:0] pcPlus4D, rdAD, rdBD, signImmD, pcBranchD, jumpTargetD;
	logic [`DATA_BITS-1:0] cmpAD, cmpBD;
	logic regWriteD, memToRegD, memWriteD, branchD, jumpD, aluSrcImmD, regDstRdD;
	logic pcSrcD, flushD;
	aluOpE aluFnD;
	// Execute
	logic [`DATA_BITS-1:0] rdAE, rdBE, signImmE, srcAE, srcBE, writeDataE, aluOutE;
	logic [4:0] rsE, rtE, rdE, writeRegE;
	logic regWriteE, memToRegE, memWriteE, aluSrcImmE, regDstRdE;
	aluOpE aluFnE;
	// Memory
	logic [`DATA_BITS-1:0] aluOutM, writeDataM;
	logic [4:0] writeRegM;
	logic regWriteM, memToRegM, memWriteM;
	// Writeback
	logic [`DATA_BITS-1:0] aluOutW, readDataW, resultW;
	logic [4:0] writeRegW;
	logic regWriteW, memToRegW;
	// Hazard
	logic stallF, stallD, flushE, forwardAD, forwardBD;
	fwdSelE forwardAE, forwardBE;

	////////////////////////////////////////////////////////////
	// Fetch
	assign pcPlus4F = pcF + PC_STEP;
	assign imemAddr = {2'b00, pcF[`DATA_BITS-1:2]};

	always_comb
	begin
		if (jumpD)
			pcNextF = jumpTargetD;
		else if (pcSrcD)
			pcNextF = pcBranchD;
		else
			pcNextF = pcPlus4F;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pcF <= `RESET_PC;
		else if (!stallF)
			pcF <= pcNextF;
	end

	// F/D, a cleared word decodes as nop
	always_ff @(posedge clk)
	begin
		if (rst)
			instrD <= '0;
		else if (!stallD)
		begin
			instrD   <= flushD ? '0 : imemData;
			pcPlus4D <= pcPlus4F;
		end
	end

	////////////////////////////////////////////////////////////
	// Decode
	controlUnit ctrl (
		.instr(instrD), .regWrite(regWriteD), .memToReg(memToRegD),
		.memWrite(memWriteD), .branch(branchD), .jump(jumpD),
		.aluSrcImm(aluSrcImmD), .regDstRd(regDstRdD), .aluOp(aluFnD)
	);

	regFile regs (
		.clk(clk), .rst(rst), .writeEn(regWriteW),
		.readAddrA(instrD.iType.rs), .readAddrB(instrD.iType.rt),
		.writeAddr(writeRegW), .writeData(resultW),
		.readDataA(rdAD), .readDataB(rdBD)
	);

	assign signImmD    = {{(`DATA_BITS-16){instrD.iType.imm[15]}}, instrD.iType.imm};
	assign pcBranchD   = pcPlus4D + (signImmD << 2);
	// Region bits of PC+4, then the 26-bit index
	assign jumpTargetD = {pcPlus4D[`DATA_BITS-1:`DATA_BITS-4], instrD.iType.rs,
		instrD.iType.rt, instrD.iType.imm, 2'b00};

	// Early compare, ALU result of M forwarded in
	assign cmpAD  = forwardAD ? aluOutM : rdAD;
	assign cmpBD  = forwardBD ? aluOutM : rdBD;
	assign pcSrcD = branchD && (cmpAD == cmpBD);
	// Slot behind a taken branch or jump is dropped
	assign flushD = pcSrcD || jumpD;

	// D/E, control and register numbers cleared for a bubble
	always_ff @(posedge clk)
	begin
		if (rst || flushE)
		begin
			regWriteE  <= 1'b0;
			memToRegE  <= 1'b0;
			memWriteE  <= 1'b0;
			aluSrcImmE <= 1'b0;
			regDstRdE  <= 1'b0;
			aluFnE     <= ALU_ADD;
			rsE        <= '0;
			rtE        <= '0;
			rdE        <= '0;
		end
		else
		begin
			regWriteE  <= regWriteD;
			memToRegE  <= memToRegD;
			memWriteE  <= memWriteD;
			aluSrcImmE <= aluSrcImmD;
			regDstRdE  <= regDstRdD;
			aluFnE     <= aluFnD;
			rsE        <= instrD.iType.rs;
			rtE        <= instrD.iType.rt;
			rdE        <= instrD.rType.rd;
		end
	end

	always_ff @(posedge clk)
	begin
		rdAE     <= rdAD;
		rdBE     <= rdBD;
		signImmE <= signImmD;
	end

	////////////////////////////////////////////////////////////
	// Execute
	always_comb
	begin
		case (forwardAE)
			FROM_M: srcAE = aluOutM;
			FROM_W: srcAE = resultW;
			default: srcAE = rdAE;
		endcase
		case (forwardBE)
			FROM_M: writeDataE = aluOutM;
			FROM_W: writeDataE = resultW;
			default: writeDataE = rdBE;
		endcase
	end

	assign srcBE     = aluSrcImmE ? signImmE : writeDataE;
	assign writeRegE = regDstRdE ? rdE : rtE;

	always_comb
	begin
		case (aluFnE)
			ALU_SUB: aluOutE = srcAE - srcBE;
			ALU_AND: aluOutE = srcAE & srcBE;
			ALU_OR:  aluOutE = srcAE | srcBE;
			// Signed compare, one in bit 0
			ALU_SLT: aluOutE = {{(`DATA_BITS-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
			default: aluOutE = srcAE + srcBE;
		endcase
	end

	// E/M
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
			writeRegM <= '0;
		end
		else
		begin
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
			writeRegM <= writeRegE;
		end
		aluOutM    <= aluOutE;
		writeDataM <= writeDataE;
	end

	////////////////////////////////////////////////////////////
	// Memory, byte address straight from the ALU
	assign dmemAddr      = aluOutM;
	assign dmemWriteData = writeDataM;
	assign dmemWriteEn   = memWriteM;

	// M/W
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
			writeRegW <= '0;
		end
		else
		begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
			writeRegW <= writeRegM;
		end
		aluOutW   <= aluOutM;
		readDataW <= dmemReadData;
	end

	// Writeback
	assign resultW = memToRegW ? readDataW : aluOutW;

	hazardUnit hazard (
		.clk(clk), .rst(rst),
		.rsD(instrD.iType.rs), .rtD(instrD.iType.rt), .rsE(rsE), .rtE(rtE),
		.writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
		.regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
		.memToRegE(memToRegE), .memToRegM(memToRegM), .branchD(branchD),
		.stallF(stallF), .stallD(stallD), .flushE(flushE),
		.forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE)
	);

endmodule

`default_nettype wire

// File: rtl/mipsTop.sv
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module mipsTop (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           loadEn,
	input  logic [$clog2(`IMEM_WORDS)-1:0] loadAddr,
	input  logic [`DATA_BITS-1:0]          loadData,
	output logic                           dmemWriteEn,
	output logic [`DATA_BITS-1:0]          dmemAddr,
	output logic [`DATA_BITS-1:0]          dmemWriteData
);

	localparam int IA_BITS = $clog2(`IMEM_WORDS);
	localparam int DA_BITS = $clog2(`DMEM_WORDS);

	logic [`DATA_BITS-1:0] imem [`IMEM_WORDS];
	logic [`DATA_BITS-1:0] dmem [`DMEM_WORDS];
	logic [`DATA_BITS-1:0] imemAddr, imemData, dmemReadData;

	mipsCore core (
		.clk(clk), .rst(rst),
		.imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData),
		.dmemWriteEn(dmemWriteEn), .dmemReadData(dmemReadData)
	);

	// Program load port, only driven during reset
	always_ff @(posedge clk)
	begin
		if (loadEn)
			imem[loadAddr] <= loadData;
	end

	assign imemData = imem[imemAddr[IA_BITS-1:0]];

	// Data memory, byte address dropped to a word index
	always_ff @(posedge clk)
	begin
		if (dmemWriteEn)
			dmem[dmemAddr[DA_BITS+1:2]] <= dmemWriteData;
	end

	assign dmemReadData = dmem[dmemAddr[DA_BITS+1:2]];

	// Writing the program under a running core would corrupt fetch
	loadOnlyInReset: assert property (@(posedge clk) loadEn |-> rst)
		else $error("mipsTop: program load outside reset");

	// Stores from the core stay inside the data memory
	storeInRange: assert property (@(posedge clk) disable iff (rst)
		dmemWriteEn |-> (dmemAddr < (`DMEM_WORDS * 4)))
		else $error("mipsTop: store address %h out of range", dmemAddr);

endmodule

`default_nettype wire

// File: sim/mipsChecker.sv
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module mipsChecker #(
	parameter int MAX_STORES = 16,
	parameter int NAME_BITS  = 128
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  dmemWriteEn,
	input  logic [`DATA_BITS-1:0] dmemAddr,
	input  logic [`DATA_BITS-1:0] dmemWriteData,
	input  int                    expCount,
	input  logic [`DATA_BITS-1:0] expAddr [MAX_STORES],
	input  logic [`DATA_BITS-1:0] expData [MAX_STORES],
	input  logic [NAME_BITS-1:0]  expName [MAX_STORES],
	output logic                  done,
	output int                    passCount,
	output int                    failCount
);

	localparam int RESET_TIMEOUT = 500;
	localparam int STORE_TIMEOUT = 200;
	// Quiet window after the last store, catches stray stores
	localparam int QUIET_CYCLES  = 40;

	initial
	begin
		int waited;
		logic seen;

		done      = 1'b0;
		passCount = 0;
		failCount = 0;
		waited    = 0;

		// Program load and reset come first, sampled on the clock
		do
		begin
			@(posedge clk);
			waited++;
		end
		while (rst && (waited < RESET_TIMEOUT));

		if (rst)
		begin
			$display("reset was never released within %0d cycles", RESET_TIMEOUT);
			failCount++;
		end
		else
		begin
			// Stores must come in program order
			for (int i = 0; i < expCount; i++)
			begin
				waited = 0;
				seen   = 1'b0;
				while (!seen && (waited < STORE_TIMEOUT))
				begin
					@(posedge clk);
					waited++;
					// Sampled before the edge updates the M stage
					if (dmemWriteEn)
						seen = 1'b1;
				end

				if (!seen)
				begin
					$display("%0s: no store arrived within %0d cycles", expName[i],
						STORE_TIMEOUT);
					failCount++;
				end
				else if ((dmemAddr !== expAddr[i]) || (dmemWriteData !== expData[i]))
				begin
					$display("FAILED %0s: expected %h at %h, actual %h at %h", expName[i],
						expData[i], expAddr[i], dmemWriteData, dmemAddr);
					failCount++;
				end
				else
				begin
					$display("passed %0s: %h at %h", expName[i], dmemWriteData, dmemAddr);
					passCount++;
				end
			end

			// Skipped or duplicated stores would show up here
			for (int c = 0; c < QUIET_CYCLES; c++)
			begin
				@(posedge clk);
				if (dmemWriteEn)
				begin
					$display("unexpected store of %h to %h after the last expected store",
						dmemWriteData, dmemAddr);
					failCount++;
				end
			end
		end

		done = 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/mipsTb.sv
`default_nettype none
`timescale 1ns/1ps
`include "mips_config.svh"

module mipsTb;

	import mipsPkg::*;

	localparam int IA_BITS      = $clog2(`IMEM_WORDS);
	localparam int DA_BITS      = $clog2(`DMEM_WORDS);
	localparam int MAX_STORES   = 16;
	localparam int NAME_BITS    = 128;
	localparam int DONE_TIMEOUT = 5000;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  loadEn;
	logic [IA_BITS-1:0]    loadAddr;
	logic [`DATA_BITS-1:0] loadData;
	logic                  dmemWriteEn;
	logic [`DATA_BITS-1:0] dmemAddr;
	logic [`DATA_BITS-1:0] dmemWriteData;

	// Program table, one name per word for stores
	instrWord              progWord [`IMEM_WORDS];
	logic [NAME_BITS-1:0]  progName [`IMEM_WORDS];
	int                    progLen;

	// Expected stores in program order
	logic [`DATA_BITS-1:0] expAddr [MAX_STORES];
	logic [`DATA_BITS-1:0] expData [MAX_STORES];
	logic [NAME_BITS-1:0]  expName [MAX_STORES];
	int                    expCount;

	logic done;
	int   passCount;
	int   failCount;
	int   seed;

	mipsTop UUT (
		.clk(clk), .rst(rst), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.dmemWriteEn(dmemWriteEn), .dmemAddr(dmemAddr), .dmemWriteData(dmemWriteData)
	);

	mipsChecker #(.MAX_STORES(MAX_STORES), .NAME_BITS(NAME_BITS)) storeCheck (
		.clk(clk), .rst(rst), .dmemWriteEn(dmemWriteEn), .dmemAddr(dmemAddr),
		.dmemWriteData(dmemWriteData), .expCount(expCount), .expAddr(expAddr),
		.expData(expData), .expName(expName), .done(done), .passCount(passCount),
		.failCount(failCount)
	);

	// 20 ns period
	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Instruction encoding

	function automatic instrWord aluInstr(functE f, logic [4:0] rd, logic [4:0] rs,
		logic [4:0] rt);
		instrWord w;
		w              = '0;
		w.rType.opcode = RTYPE;
		w.rType.rs     = rs;
		w.rType.rt     = rt;
		w.rType.rd     = rd;
		w.rType.funct  = f;
		return w;
	endfunction

	function automatic instrWord immInstr(opcodeE op, logic [4:0] rt, logic [4:0] rs,
		logic [15:0] imm);
		instrWord w;
		w              = '0;
		w.iType.opcode = op;
		w.iType.rs     = rs;
		w.iType.rt     = rt;
		w.iType.imm    = imm;
		return w;
	endfunction

	// Target is a word index
	function automatic instrWord jumpInstr(int target);
		instrWord w;
		logic [25:0] t;
		t              = target[25:0];
		w.iType.opcode = J;
		w.iType.rs     = t[25:21];
		w.iType.rt     = t[20:16];
		w.iType.imm    = t[15:0];
		return w;
	endfunction

	// Text into a fixed-width vector for the checker
	function automatic logic [NAME_BITS-1:0] nameBits(string s);
		logic [NAME_BITS-1:0] v;
		v = '0;
		for (int i = 0; i < s.len(); i++)
			v = {v[NAME_BITS-9:0], s[i]};
		return v;
	endfunction

	task automatic addToProgram(input instrWord w, input string name);
		progWord[progLen] = w;
		progName[progLen] = nameBits(name);
		progLen++;
	endtask

	////////////////////////////////////////////////////////////
	// Program, word index in the comments

	task automatic writeProgram();
		logic [`DATA_BITS-1:0] r;

		progLen = 0;
		// 0..11 chained ALU results, forwarding from M and W
		r = $random(seed);
		addToProgram(immInstr(ADDI, 5'd1, 5'd0, r[15:0]), "");
		r = $random(seed);
		addToProgram(immInstr(ADDI, 5'd2, 5'd0, r[15:0]), "");
		addToProgram(aluInstr(ADD, 5'd3, 5'd1, 5'd2), "");
		addToProgram(aluInstr(SUB, 5'd4, 5'd3, 5'd1), "");
		addToProgram(aluInstr(AND, 5'd5, 5'd4, 5'd3), "");
		addToProgram(aluInstr(OR, 5'd6, 5'd5, 5'd4), "");
		// Store data straight from M
		addToProgram(immInstr(SW, 5'd6, 5'd0, 16'd12), "aluOr");
		addToProgram(aluInstr(SLT, 5'd7, 5'd6, 5'd5), "");
		addToProgram(immInstr(SW, 5'd3, 5'd0, 16'd0), "aluAdd");
		addToProgram(immInstr(SW, 5'd4, 5'd0, 16'd4), "aluSub");
		addToProgram(immInstr(SW, 5'd5, 5'd0, 16'd8), "aluAnd");
		addToProgram(immInstr(SW, 5'd7, 5'd0, 16'd16), "aluSlt");
		// 12..14 load then immediate use
		addToProgram(immInstr(LW, 5'd8, 5'd0, 16'd0), "");
		addToProgram(aluInstr(ADD, 5'd9, 5'd8, 5'd1), "");
		addToProgram(immInstr(SW, 5'd9, 5'd0, 16'd20), "loadUse");
		// 15..24 taken beq on a register still in E, then j
		r = $random(seed);
		addToProgram(immInstr(ADDI, 5'd10, 5'd0, r[15:0]), "");
		addToProgram(aluInstr(ADD, 5'd11, 5'd10, 5'd0), "");
		addToProgram(immInstr(BEQ, 5'd11, 5'd10, 16'd2), "");
		addToProgram(immInstr(SW, 5'd10, 5'd0, 16'd24), "skippedA");
		addToProgram(immInstr(SW, 5'd11, 5'd0, 16'd28), "skippedB");
		r = $random(seed);
		addToProgram(immInstr(ADDI, 5'd12, 5'd0, r[15:0]), "");
		addToProgram(immInstr(SW, 5'd12, 5'd0, 16'd32), "branchTarget");
		addToProgram(jumpInstr(24), "");
		addToProgram(immInstr(SW, 5'd12, 5'd0, 16'd36), "skippedC");
		addToProgram(immInstr(SW, 5'd11, 5'd0, 16'd40), "jumpTarget");
		// 25..27 beq that can never be taken
		addToProgram(immInstr(ADDI, 5'd13, 5'd1, 16'd1), "");
		addToProgram(immInstr(BEQ, 5'd13, 5'd1, 16'd1), "");
		addToProgram(immInstr(SW, 5'd13, 5'd0, 16'd44), "notTaken");
		// 28..32 writes to r0 go nowhere
		r = $random(seed);
		addToProgram(immInstr(ADDI, 5'd0, 5'd0, r[15:0]), "");
		addToProgram(aluInstr(ADD, 5'd0, 5'd1, 5'd2), "");
		addToProgram(immInstr(SW, 5'd0, 5'd0, 16'd52), "zeroStore");
		addToProgram(aluInstr(ADD, 5'd14, 5'd0, 5'd0), "");
		addToProgram(immInstr(SW, 5'd14, 5'd0, 16'd48), "zeroAdd");
		// 33 parks the core, 34 is a nop behind it
		addToProgram(jumpInstr(33), "");
		addToProgram('0, "");
	endtask

	////////////////////////////////////////////////////////////
	// Reference model, one instruction at a time

	task automatic runReference();
		logic [`DATA_BITS-1:0] refRegs [32];
		logic [`DATA_BITS-1:0] refMem [`DMEM_WORDS];
		logic [`DATA_BITS-1:0] a, b, imm, addr, res;
		logic [25:0] tgt;
		logic running, wr;
		instrWord w;
		int pc, steps;

		for (int i = 0; i < 32; i++)
			refRegs[i] = '0;
		for (int i = 0; i < `DMEM_WORDS; i++)
			refMem[i] = '0;
		expCount = 0;
		pc       = 0;
		steps    = 0;
		running  = 1'b1;
		res      = '0;

		while (running && (steps < 500) && (pc < progLen))
		begin
			w    = progWord[pc];
			a    = refRegs[w.iType.rs];
			b    = refRegs[w.iType.rt];
			imm  = {{16{w.iType.imm[15]}}, w.iType.imm};
			addr = a + imm;
			steps++;
			case (w.rType.opcode)
				RTYPE:
				begin
					wr = 1'b1;
					case (w.rType.funct)
						ADD: res = a + b;
						SUB: res = a - b;
						AND: res = a & b;
						OR:  res = a | b;
						SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: wr = 1'b0;
					endcase
					if (wr && (w.rType.rd != 5'd0))
						refRegs[w.rType.rd] = res;
					pc++;
				end
				ADDI:
				begin
					if (w.iType.rt != 5'd0)
						refRegs[w.iType.rt] = addr;
					pc++;
				end
				LW:
				begin
					if (w.iType.rt != 5'd0)
						refRegs[w.iType.rt] = refMem[addr[DA_BITS+1:2]];
					pc++;
				end
				SW:
				begin
					refMem[addr[DA_BITS+1:2]] = b;
					if (expCount < MAX_STORES)
					begin
						expAddr[expCount] = addr;
						expData[expCount] = b;
						expName[expCount] = progName[pc];
						expCount++;
					end
					pc++;
				end
				// Offset counts words from the next instruction
				BEQ: pc = (a == b) ? (pc + 1 + int'($signed(w.iType.imm))) : (pc + 1);
				J:
				begin
					tgt = {w.iType.rs, w.iType.rt, w.iType.imm};
					if (int'(tgt) == pc)
						running = 1'b0;
					else
						pc = int'(tgt);
				end
				default: pc++;
			endcase
		end
	endtask

	////////////////////////////////////////////////////////////
	// Load, release reset, wait for the checker

	initial
	begin
		int waited;

		rst      <= 1'b1;
		loadEn   <= 1'b0;
		loadAddr <= '0;
		loadData <= '0;
		seed     = 32'h78ce;
		waited   = 0;

		writeProgram();
		runReference();

		// One word per rising edge while the core sits in reset
		for (int i = 0; i < progLen; i++)
		begin
			@(posedge clk);
			loadEn   <= 1'b1;
			loadAddr <= IA_BITS'(i);
			loadData <= progWord[i];
		end
		@(posedge clk);
		loadEn <= 1'b0;

		// Reset stays on for 4 cycles past the load
		repeat (4) @(posedge clk);
		rst <= 1'b0;

		while (!done && (waited < DONE_TIMEOUT))
		begin
			@(posedge clk);
			waited++;
		end

		if (!done)
			$display("checker did not finish within %0d cycles", DONE_TIMEOUT);
		$display("stores passed %0d, failed %0d", passCount, failCount);
		if (done && (failCount == 0))
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/controlUnit.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/mipsCore.sv
rtl/mipsTop.sv
sim/mipsChecker.sv
sim/mipsTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the MIPS pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mipsTb -f sim.f

output="$(./obj_dir/VmipsTb)"
echo "$output"

# Pass only if the testbench printed the pass line
grep -qx "NO ERRORS" <<< "$output"
